//--- hdl/csr_pkg.sv
/*
 * machine-mode csr definitions shared by decode, execute and result
 * csr indices, funct3 and cause codes, field positions, stage structs
 */
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int CAUSE_W    = 4;

    localparam logic [XLEN-1:0] RESET_TRAP_ADDR = 32'h0000_0000; // direct mode, base 0

    // csr indices
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISA     = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL    = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP      = 12'h344;

    // csr op encodings, bit 2 picks the immediate operand
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    // mcause codes (interrupts carry bit 31 on top)
    localparam logic [CAUSE_W-1:0] CAUSE_SW_IRQ         = 4'd3;
    localparam logic [CAUSE_W-1:0] CAUSE_TIMER_IRQ      = 4'd7;
    localparam logic [CAUSE_W-1:0] CAUSE_EXT_IRQ        = 4'd11;
    localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL        = 4'd2;
    localparam logic [CAUSE_W-1:0] CAUSE_EBREAK         = 4'd3;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_MISALIGN  = 4'd4;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_MISALIGN = 4'd6;
    localparam logic [CAUSE_W-1:0] CAUSE_ECALL          = 4'd11;

    // field positions
    localparam int BIT_MIE  = 3;  // mstatus
    localparam int BIT_MPIE = 7;
    localparam int BIT_MPP  = 11; // two bits, 12:11
    localparam int BIT_MSIE = 3;  // mie
    localparam int BIT_MTIE = 7;
    localparam int BIT_MEIE = 11;
    localparam int BIT_MSIP = 3;  // mip, same layout as mie
    localparam int BIT_MTIP = 7;
    localparam int BIT_MEIP = 11;
    localparam int BIT_INTR = 31; // mcause

    localparam logic [1:0]      MPP_MACHINE = 2'b11;        // only m-mode exists
    localparam logic [XLEN-1:0] MISA_VALUE  = 32'h4000_0100; // rv32, I extension

    typedef struct packed {
        logic ext;
        logic sw;
        logic timer;
    } irq_lines_t;

    typedef struct packed {
        logic system;
        logic load;
        logic store;
        logic illegal;
        logic ecall;
        logic ebreak;
    } inst_class_t;

    typedef struct packed {
        logic                  valid;
        inst_class_t           cls;
        logic                  mret;
        logic [2:0]            funct3;
        logic [CSR_ADDR_W-1:0] csr_idx;
        logic [XLEN-1:0]       rs1;
        logic [XLEN-1:0]       imm;    // zero-extended uimm
        logic [XLEN-1:0]       addr;   // effective load/store address
        logic [XLEN-1:0]       pc;
    } csr_inst_t;

    typedef struct packed {
        logic mie;  // mstatus global enable
        logic msie;
        logic mtie;
        logic meie;
        logic msip;
        logic mtip;
        logic meip;
    } irq_state_t;

    typedef struct packed {
        logic                  csr_we;
        logic [2:0]            funct3;
        logic [CSR_ADDR_W-1:0] csr_idx;
        logic [XLEN-1:0]       operand;
        logic                  take_trap;
        logic                  is_irq;
        logic [CAUSE_W-1:0]    cause;
        logic                  tval_valid;
        logic [XLEN-1:0]       tval;
        logic [XLEN-1:0]       pc;
        logic                  mret;
    } trap_req_t;

    typedef struct packed {
        logic               take_trap;
        logic               mret;
        logic               is_irq;
        logic [CAUSE_W-1:0] cause;
        logic [XLEN-1:0]    mtvec;
        logic [XLEN-1:0]    mepc;
        logic [XLEN-1:0]    rdata;
    } exec_out_t;

    typedef struct packed {
        logic            go_to_trap;
        logic            return_from_trap;
        logic [XLEN-1:0] trap_addr;
        logic [XLEN-1:0] return_addr;
    } trap_out_t;

endpackage

//--- hdl/csr_decode.sv
/*
 * csr decode: picks the write operand, checks load/store alignment,
 * qualifies interrupts and arbitrates the trap cause
 */
`timescale 1ns/1ns

module csr_decode import csr_pkg::*; (
    input  csr_inst_t  i_inst,
    input  irq_state_t i_irq_state,
    output trap_req_t  o_req
);

    logic               addr_mis;     // access not aligned to its size
    logic               ld_mis;
    logic               st_mis;
    logic               ext_pend;
    logic               sw_pend;
    logic               tmr_pend;
    logic               irq_any;
    logic               exc_any;
    logic               take;
    logic               is_irq;
    logic               tval_vld;
    logic [CAUSE_W-1:0] cause;

    // access size lives in funct3[1:0]
    always_comb begin
        case (i_inst.funct3[1:0])
            2'b01:   addr_mis = i_inst.addr[0];              // halfword
            2'b10:   addr_mis = (i_inst.addr[1:0] != 2'b00); // word
            default: addr_mis = 1'b0;                        // bytes never fault
        endcase
    end

    assign ld_mis = i_inst.cls.load && addr_mis;
    assign st_mis = i_inst.cls.store && addr_mis;

    // global enable and per-source enable and pending
    assign ext_pend = i_irq_state.mie && i_irq_state.meie && i_irq_state.meip;
    assign sw_pend  = i_irq_state.mie && i_irq_state.msie && i_irq_state.msip;
    assign tmr_pend = i_irq_state.mie && i_irq_state.mtie && i_irq_state.mtip;

    assign irq_any = ext_pend || sw_pend || tmr_pend;
    assign exc_any = i_inst.cls.illegal || i_inst.cls.ecall || i_inst.cls.ebreak
                     || ld_mis || st_mis;
    assign take    = i_inst.valid && (irq_any || exc_any);

    ////////////////////
    // cause priority
    ////////////////////
    always_comb begin
        is_irq   = 1'b0;
        tval_vld = 1'b0;
        cause    = '0;
        if (ext_pend) begin
            is_irq = 1'b1;
            cause  = CAUSE_EXT_IRQ;
        end else if (sw_pend) begin
            is_irq = 1'b1;
            cause  = CAUSE_SW_IRQ;
        end else if (tmr_pend) begin
            is_irq = 1'b1;
            cause  = CAUSE_TIMER_IRQ;
        end else if (i_inst.cls.illegal) begin
            cause = CAUSE_ILLEGAL;
        end else if (i_inst.cls.ecall) begin
            cause = CAUSE_ECALL;
        end else if (i_inst.cls.ebreak) begin
            cause = CAUSE_EBREAK;
        end else if (ld_mis) begin
            cause    = CAUSE_LOAD_MISALIGN;
            tval_vld = 1'b1; // faulting address goes to mtval
        end else if (st_mis) begin
            cause    = CAUSE_STORE_MISALIGN;
            tval_vld = 1'b1;
        end
    end

    always_comb begin
        o_req.csr_we     = i_inst.valid && i_inst.cls.system && (i_inst.funct3 != 3'b000)
                           && !take; // a trapping instruction never writes
        o_req.funct3     = i_inst.funct3;
        o_req.csr_idx    = i_inst.csr_idx;
        o_req.operand    = i_inst.funct3[2] ? i_inst.imm : i_inst.rs1;
        o_req.take_trap  = take;
        o_req.is_irq     = is_irq;
        o_req.cause      = cause;
        o_req.tval_valid = tval_vld;
        o_req.tval       = i_inst.addr;
        o_req.pc         = i_inst.pc;
        o_req.mret       = i_inst.valid && i_inst.mret && !take;
    end

endmodule

//--- hdl/csr_execute.sv
/*
 * csr execute: machine csr state, read mux, read-modify-write,
 * and the mstatus/mepc/mcause/mtval updates for trap entry and mret
 */
`timescale 1ns/1ns

module csr_execute import csr_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  irq_lines_t i_irq,
    input  trap_req_t  i_req,
    output irq_state_t o_irq_state,
    output exec_out_t  o_exec
);

    // implemented fields only
    logic               mstatus_mie;
    logic               mstatus_mpie;
    logic               mie_msie;
    logic               mie_mtie;
    logic               mie_meie;
    logic [XLEN-3:0]    mtvec_base;   // 4-byte aligned base
    logic               mtvec_vec;    // 1 = vectored
    logic [XLEN-1:0]    mscratch;
    logic [XLEN-1:0]    mepc;
    logic               mcause_intr;
    logic [CAUSE_W-1:0] mcause_code;
    logic [XLEN-1:0]    mtval;
    logic               mip_msip;
    logic               mip_mtip;
    logic               mip_meip;

    logic [XLEN-1:0]    mtvec_val;
    logic [XLEN-1:0]    rdata;        // value before this instruction
    logic [XLEN-1:0]    wdata;        // value after write/set/clear

    assign mtvec_val = {mtvec_base, 1'b0, mtvec_vec};

    ////////////////////
    // read mux
    ////////////////////
    always_comb begin
        rdata = '0; // unknown index reads zero
        case (i_req.csr_idx)
            CSR_MSTATUS: begin
                rdata[BIT_MIE]      = mstatus_mie;
                rdata[BIT_MPIE]     = mstatus_mpie;
                rdata[BIT_MPP +: 2] = MPP_MACHINE;
            end
            CSR_MISA:     rdata = MISA_VALUE;
            CSR_MIE: begin
                rdata[BIT_MSIE] = mie_msie;
                rdata[BIT_MTIE] = mie_mtie;
                rdata[BIT_MEIE] = mie_meie;
            end
            CSR_MTVEC:    rdata = mtvec_val;
            CSR_MSCRATCH: rdata = mscratch;
            CSR_MEPC:     rdata = mepc;
            CSR_MCAUSE: begin
                rdata[BIT_INTR]      = mcause_intr;
                rdata[CAUSE_W-1:0]   = mcause_code;
            end
            CSR_MTVAL:    rdata = mtval;
            CSR_MIP: begin
                rdata[BIT_MSIP] = mip_msip;
                rdata[BIT_MTIP] = mip_mtip;
                rdata[BIT_MEIP] = mip_meip;
            end
            default:      rdata = '0;
        endcase
    end

    // operand already picked between rs1 and uimm in decode
    always_comb begin
        case (i_req.funct3)
            F3_CSRRW, F3_CSRRWI: wdata = i_req.operand;
            F3_CSRRS, F3_CSRRSI: wdata = rdata | i_req.operand;
            F3_CSRRC, F3_CSRRCI: wdata = rdata & ~i_req.operand;
            default:             wdata = rdata;
        endcase
    end

    ////////////////////
    // state update
    ////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_msie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mie_meie     <= 1'b0;
            mtvec_base   <= RESET_TRAP_ADDR[XLEN-1:2];
            mtvec_vec    <= RESET_TRAP_ADDR[0];
            mscratch     <= '0;
            mepc         <= '0;
            mcause_intr  <= 1'b0;
            mcause_code  <= '0;
            mtval        <= '0;
            mip_msip     <= 1'b0;
            mip_mtip     <= 1'b0;
            mip_meip     <= 1'b0;
        end else begin
            // pending bits follow the lines every cycle, valid or not
            mip_msip <= i_irq.sw;
            mip_mtip <= i_irq.timer;
            mip_meip <= i_irq.ext;

            if (i_req.csr_we) begin // already masked by take_trap in decode
                case (i_req.csr_idx)
                    CSR_MSTATUS: begin
                        mstatus_mie  <= wdata[BIT_MIE];
                        mstatus_mpie <= wdata[BIT_MPIE];
                    end
                    CSR_MIE: begin
                        mie_msie <= wdata[BIT_MSIE];
                        mie_mtie <= wdata[BIT_MTIE];
                        mie_meie <= wdata[BIT_MEIE];
                    end
                    CSR_MTVEC: begin
                        mtvec_base <= wdata[XLEN-1:2];
                        mtvec_vec  <= wdata[0];
                    end
                    CSR_MSCRATCH: mscratch <= wdata;
                    CSR_MEPC:     mepc     <= {wdata[XLEN-1:2], 2'b00};
                    CSR_MCAUSE: begin
                        mcause_intr <= wdata[BIT_INTR];
                        mcause_code <= wdata[CAUSE_W-1:0];
                    end
                    CSR_MTVAL:    mtval    <= wdata;
                    default: ;    // misa, mip and unknown indices ignore writes
                endcase
            end

            if (i_req.take_trap) begin
                mepc         <= i_req.pc;
                mcause_intr  <= i_req.is_irq;
                mcause_code  <= i_req.cause;
                mstatus_mpie <= mstatus_mie; // stack the enable
                mstatus_mie  <= 1'b0;        // no nesting until mret
                if (i_req.tval_valid) begin
                    mtval <= i_req.tval;
                end
            end else if (i_req.mret) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end
        end
    end

    assign o_irq_state = '{mie:  mstatus_mie,
                           msie: mie_msie,
                           mtie: mie_mtie,
                           meie: mie_meie,
                           msip: mip_msip,
                           mtip: mip_mtip,
                           meip: mip_meip};

    assign o_exec = '{take_trap: i_req.take_trap,
                      mret:      i_req.mret,
                      is_irq:    i_req.is_irq,
                      cause:     i_req.cause,
                      mtvec:     mtvec_val,
                      mepc:      mepc,      // pre-edge value for the return address
                      rdata:     rdata};

endmodule

//--- hdl/csr_result.sv
/*
 * csr result: registers the trap and mret pulses, trap vector,
 * return address and csr read data seen by fetch and writeback
 */
`timescale 1ns/1ns

module csr_result import csr_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  exec_out_t       i_exec,
    output trap_out_t       o_trap,
    output logic [XLEN-1:0] o_csr_data
);

    logic            go_q;
    logic            ret_q;
    logic [XLEN-1:0] trap_addr_q;
    logic [XLEN-1:0] ret_addr_q;
    logic [XLEN-1:0] csr_data_q;
    logic [XLEN-1:0] vec_base;
    logic [XLEN-1:0] vec_off;

    // vectored mode adds 4*cause for interrupts only, using this trap's cause
    assign vec_base = {i_exec.mtvec[XLEN-1:2], 2'b00};
    assign vec_off  = (i_exec.mtvec[0] && i_exec.is_irq)
                      ? {{(XLEN-CAUSE_W-2){1'b0}}, i_exec.cause, 2'b00}
                      : '0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            go_q  <= 1'b0;
            ret_q <= 1'b0;
        end else begin
            go_q  <= i_exec.take_trap; // one-cycle pulses
            ret_q <= i_exec.mret;
        end
    end

    always_ff @(posedge i_clk) begin
        trap_addr_q <= vec_base + vec_off;
        ret_addr_q  <= i_exec.mepc;
        csr_data_q  <= i_exec.rdata;
    end

    assign o_trap = '{go_to_trap:       go_q,
                      return_from_trap: ret_q,
                      trap_addr:        trap_addr_q,
                      return_addr:      ret_addr_q};

    assign o_csr_data = csr_data_q;

endmodule

//--- hdl/csr_unit.sv
/*
 * machine-mode csr unit for a small rv32i core
 * decode -> execute -> result, one cycle input to output
 */
`timescale 1ns/1ns

module csr_unit import csr_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  csr_inst_t       i_inst,
    input  irq_lines_t      i_irq,
    output trap_out_t       o_trap,
    output logic [XLEN-1:0] o_csr_data
);

    trap_req_t  req;       // decode to execute, combinational
    irq_state_t irq_state; // enables and pending bits fed back to decode
    exec_out_t  exec_out;  // execute to result

    csr_decode u_decode (
        .i_inst      (i_inst),
        .i_irq_state (irq_state),
        .o_req       (req)
    );

    csr_execute u_execute (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_irq       (i_irq),
        .i_req       (req),
        .o_irq_state (irq_state),
        .o_exec      (exec_out)
    );

    // only register stage between the input edge and the outputs
    csr_result u_result (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_exec      (exec_out),
        .o_trap      (o_trap),
        .o_csr_data  (o_csr_data)
    );

endmodule

//--- tb/csr_unit_asserts.sv
/*
 * pulse checks on the csr unit outputs, bound into csr_unit
 */
`timescale 1ns/1ns

module csr_unit_asserts import csr_pkg::*; (
    input logic      i_clk,
    input logic      i_rst_n,
    input csr_inst_t i_inst,
    input trap_out_t i_trap
);

    // trap entry and return exclude each other
    a_one_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_trap.go_to_trap && i_trap.return_from_trap))
        else $error("go_to_trap and return_from_trap high together");

    // one cycle latency from a valid instruction
    a_after_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_trap.go_to_trap || i_trap.return_from_trap) |-> $past(i_inst.valid))
        else $error("trap pulse without a valid instruction the cycle before");

    a_reset_quiet: assert property (@(posedge i_clk)
        !i_rst_n |-> (!i_trap.go_to_trap && !i_trap.return_from_trap))
        else $error("trap pulse during reset");

endmodule

bind csr_unit csr_unit_asserts u_asserts (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_inst  (i_inst),
    .i_trap  (o_trap)
);

//--- tb/tb_csr_unit.sv
/*
 * testbench for the machine-mode csr unit
 * directed tests for csr ops, field masks, exceptions, interrupts and mret
 */
`timescale 1ns/1ns

module tb_csr_unit import csr_pkg::*; ();

    localparam int MAX_CYCLES = 2000; // tests need ~130 cycles, generous margin

    logic            clk;
    logic            rst_n;
    csr_inst_t       inst;
    irq_lines_t      irq;
    trap_out_t       trap;
    logic [XLEN-1:0] csr_data;

    string           test_name;
    int              cycles = 0;
    logic [XLEN-1:0] m_scratch;   // reference copy of mscratch
    trap_out_t       got_trap;    // outputs one cycle after an instruction
    logic [XLEN-1:0] got_data;

    csr_unit u_dut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_inst     (inst),
        .i_irq      (irq),
        .o_trap     (trap),
        .o_csr_data (csr_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    ////////////////////
    // checks
    ////////////////////
    task automatic check_eq(input string what, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
        assert (act === exp) else begin
            $display("ERR %s: %s expected %h actual %h", test_name, what, exp, act);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("ERR %s: %s expected %b actual %b", test_name, what, exp, act);
            $display("sim failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    ////////////////////
    // stimulus helpers
    ////////////////////
    function automatic csr_inst_t csr_op(input logic [2:0] f3,
                                         input logic [CSR_ADDR_W-1:0] idx,
                                         input logic [XLEN-1:0] rs1,
                                         input logic [XLEN-1:0] imm);
        csr_inst_t t;
        t            = '0;
        t.valid      = 1'b1;
        t.cls.system = 1'b1;
        t.funct3     = f3;
        t.csr_idx    = idx;
        t.rs1        = rs1;
        t.imm        = imm;
        t.pc         = 32'h0000_0400;
        return t;
    endfunction

    // drive on the falling edge, capture one falling edge later
    task automatic run_inst(input csr_inst_t t);
        @(negedge clk);
        inst = t;
        @(negedge clk);       // registered at the rising edge in between
        inst     = '0;        // back to idle so it is not taken twice
        got_trap = trap;
        got_data = csr_data;
    endtask

    task automatic set_irq(input irq_lines_t lines);
        @(negedge clk);
        irq = lines;
        @(negedge clk);       // mip has sampled the lines
    endtask

    task automatic write_csr(input logic [CSR_ADDR_W-1:0] idx, input logic [XLEN-1:0] val);
        run_inst(csr_op(F3_CSRRW, idx, val, '0));
    endtask

    // a read is csrrs with rs1 zero
    task automatic expect_csr(input string what, input logic [CSR_ADDR_W-1:0] idx,
                              input logic [XLEN-1:0] exp);
        run_inst(csr_op(F3_CSRRS, idx, '0, '0));
        check_bit({what, " no trap on read"}, 1'b0, got_trap.go_to_trap);
        check_eq(what, exp, got_data);
    endtask

    task automatic expect_trap(input csr_inst_t t, input logic [XLEN-1:0] addr);
        run_inst(t);
        check_bit("go_to_trap", 1'b1, got_trap.go_to_trap);
        check_bit("return_from_trap", 1'b0, got_trap.return_from_trap);
        check_eq("trap address", addr, got_trap.trap_addr);
    endtask

    ////////////////////
    // tests
    ////////////////////
    task automatic test_rmw();
        logic [2:0]      ops [6];
        logic [2:0]      f3;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] opnd;
        ops       = '{F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI};
        test_name = "rmw";
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < 6; k++) begin
                f3   = ops[k];
                rs1  = $urandom;
                imm  = $urandom & 32'h0000_001f; // 5-bit uimm
                opnd = f3[2] ? imm : rs1;
                run_inst(csr_op(f3, CSR_MSCRATCH, rs1, imm));
                check_eq("mscratch old value", m_scratch, got_data);
                case (f3[1:0])
                    2'b01:   m_scratch = opnd;              // write
                    2'b10:   m_scratch = m_scratch | opnd;  // set
                    default: m_scratch = m_scratch & ~opnd; // clear
                endcase
            end
        end
        expect_csr("mscratch final", CSR_MSCRATCH, m_scratch);
    endtask

    task automatic test_fields();
        test_name = "fields";
        write_csr(CSR_MSTATUS, '1);
        write_csr(CSR_MIE, '1);
        write_csr(CSR_MTVEC, '1);
        write_csr(CSR_MEPC, '1);
        write_csr(12'h7c0, '1);                                     // unknown index
        expect_csr("mstatus fields", CSR_MSTATUS, 32'h0000_1888);   // mpp 11, mpie, mie
        expect_csr("mie enables", CSR_MIE, 32'h0000_0888);
        expect_csr("mtvec base and mode", CSR_MTVEC, 32'hffff_fffd);
        expect_csr("mepc low bits", CSR_MEPC, 32'hffff_fffc);
        expect_csr("misa", CSR_MISA, 32'h4000_0100);                // rv32, I
        expect_csr("unknown index", 12'h7c0, 32'h0000_0000);
        expect_csr("mip idle", CSR_MIP, 32'h0000_0000);
        // quiet state, direct vector at 0x100
        write_csr(CSR_MSTATUS, '0);
        write_csr(CSR_MIE, '0);
        write_csr(CSR_MTVEC, 32'h0000_0100);
    endtask

    task automatic test_exceptions();
        csr_inst_t t;
        test_name = "exceptions";
        t           = csr_op(F3_CSRRW, CSR_MSCRATCH, 32'hdead_beef, '0);
        t.cls.ecall = 1'b1;      // carries a csr write that must be dropped
        t.addr      = 32'h0000_5a5a; // stray address, mtval must ignore it
        t.pc        = 32'h0000_0810;
        expect_trap(t, 32'h0000_0100);
        expect_csr("mepc after ecall", CSR_MEPC, 32'h0000_0810);
        expect_csr("mcause after ecall", CSR_MCAUSE, 32'd11);
        expect_csr("mtval after ecall", CSR_MTVAL, 32'h0000_0000);

        t.cls.ecall   = 1'b0;
        t.cls.illegal = 1'b1;
        t.pc          = 32'h0000_0820;
        expect_trap(t, 32'h0000_0100);
        expect_csr("mcause after illegal", CSR_MCAUSE, 32'd2);
        expect_csr("mepc after illegal", CSR_MEPC, 32'h0000_0820);
        expect_csr("mtval after illegal", CSR_MTVAL, 32'h0000_0000);
        expect_csr("mscratch untouched", CSR_MSCRATCH, m_scratch);

        t          = '0;
        t.valid    = 1'b1;
        t.cls.load = 1'b1;
        t.funct3   = 3'b010;     // word load
        t.addr     = 32'h0000_2004;
        t.pc       = 32'h0000_0830;
        run_inst(t);
        check_bit("aligned load", 1'b0, got_trap.go_to_trap);
        t.addr = 32'h0000_2002;
        expect_trap(t, 32'h0000_0100);
        expect_csr("mcause load misaligned", CSR_MCAUSE, 32'd4);
        expect_csr("mtval load address", CSR_MTVAL, 32'h0000_2002);

        t.cls.load  = 1'b0;
        t.cls.store = 1'b1;
        t.funct3    = 3'b001;    // halfword store
        t.addr      = 32'h0000_3001;
        expect_trap(t, 32'h0000_0100);
        expect_csr("mcause store misaligned", CSR_MCAUSE, 32'd6);
        expect_csr("mtval store address", CSR_MTVAL, 32'h0000_3001);
    endtask

    task automatic test_irq();
        csr_inst_t t;
        test_name = "interrupts";
        write_csr(CSR_MTVEC, 32'h0000_0201);   // vectored, base 0x200
        write_csr(CSR_MIE, 32'h0000_0088);     // msie and mtie
        write_csr(CSR_MSTATUS, 32'h0000_0008); // global enable
        set_irq(3'b011);                       // {ext, sw, timer}
        t       = '0;
        t.valid = 1'b1;
        t.pc    = 32'h0000_0900;
        expect_trap(t, 32'h0000_020c);         // software wins, base + 4*3
        expect_csr("mepc after irq", CSR_MEPC, 32'h0000_0900);
        expect_csr("mcause after irq", CSR_MCAUSE, 32'h8000_0003);
        expect_csr("mstatus after irq", CSR_MSTATUS, 32'h0000_1880);
        run_inst(t);                           // lines still high, mie clear
        check_bit("no second interrupt", 1'b0, got_trap.go_to_trap);
        set_irq(3'b000);
    endtask

    task automatic test_mret();
        csr_inst_t t;
        test_name = "mret";
        write_csr(CSR_MEPC, 32'h0000_0a36);    // low bits dropped on write
        t       = '0;
        t.valid = 1'b1;
        t.mret  = 1'b1;
        t.pc    = 32'h0000_0950;
        run_inst(t);
        check_bit("return_from_trap", 1'b1, got_trap.return_from_trap);
        check_bit("go_to_trap", 1'b0, got_trap.go_to_trap);
        check_eq("return address", 32'h0000_0a34, got_trap.return_addr);
        expect_csr("mstatus after mret", CSR_MSTATUS, 32'h0000_1888); // mie from mpie
    endtask

    initial begin
        void'($urandom(88496));
        rst_n     = 1'b0;
        inst      = '0;
        irq       = '0;
        m_scratch = '0;
        test_name = "reset";
        repeat (10) @(negedge clk);
        check_bit("go_to_trap in reset", 1'b0, trap.go_to_trap);
        check_bit("return_from_trap in reset", 1'b0, trap.return_from_trap);
        rst_n = 1'b1;
        test_rmw();
        test_fields();
        test_exceptions();
        test_irq();
        test_mret();
        $display("sim passed");
        $finish;
    end

endmodule

//--- filelist.f
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/csr_execute.sv
hdl/csr_result.sv
hdl/csr_unit.sv
tb/csr_unit_asserts.sv
tb/tb_csr_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_csr_unit
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
